// ==== source/pcie_scramble_config.svh ====
`ifndef PCIE_SCRAMBLE_CONFIG_SVH
`define PCIE_SCRAMBLE_CONFIG_SVH

// lfsr restart value
// loaded at reset and after every COM
`define SCR_SEED 16'hFFFF

// COM K-code (K28.5 before 8b/10b)
`define SCR_COM 8'hBC

// byte lanes per pipe word
// fixed at four, the only width supported
`define SCR_LANES 4

// bits per symbol, excluding the K flag
`define SCR_SYM_W 8

`endif

// ==== source/pcie_scramble_pkg.sv ====
`default_nettype none

`include "pcie_scramble_config.svh"

package pcie_scramble_pkg;

  // active width of a pipe word
  // only the low lanes carry symbols
  typedef enum logic [1:0] {
    width_8  = 2'd0,
    width_16 = 2'd1,
    width_32 = 2'd2
  } lane_width_e;

  // one symbol, K flag on top of the byte
  typedef struct packed {
    logic                  k;
    logic [`SCR_SYM_W-1:0] data;
  } pipe_sym_t;

  // full pipe word
  // index 0 is lane 0, the low bits
  typedef struct packed {
    pipe_sym_t [`SCR_LANES-1:0] sym;
  } pipe_word_t;

  // keystream for one word
  // next_state already picked for the active width
  typedef struct packed {
    logic [15:0]                             next_state;
    logic [`SCR_LANES-1:0][`SCR_SYM_W-1:0] key;
  } key_word_t;

  // per-lane masks from the classifier
  typedef struct packed {
    logic [`SCR_LANES-1:0] active;
    logic [`SCR_LANES-1:0] ctrl;
    logic [`SCR_LANES-1:0] com;
  } lane_flags_t;

endpackage

`default_nettype wire

// ==== source/lfsr_byte_step.sv ====
`timescale 1ns/1ps
`default_nettype none

module lfsr_byte_step (
  input  logic [15:0] state_i,
  output logic [7:0]  key_o,
  output logic [15:0] state_o
);

  // eight serial shifts of the galois lfsr, unrolled
  // poly x^16+x^5+x^4+x^3+1, taps land on bits 0,3,4,5
  always_comb begin : step_comb
    logic [15:0] lfsr;
    lfsr = state_i;
    for (int i = 0; i < 8; i++) begin
      // bit 0 of the byte goes on the line first
      // so key bit i is the msb before shift i
      key_o[i] = lfsr[15];
      // shift left, feed msb back into the taps
      lfsr = {lfsr[14:0], 1'b0} ^ ({16{lfsr[15]}} & 16'h0039);
    end
    // state after one full byte time
    state_o = lfsr;
  end

endmodule

`default_nettype wire

// ==== source/scramble_keystream.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pcie_scramble_config.svh"

module scramble_keystream
  import pcie_scramble_pkg::*;
(
  input  logic [15:0] state_i,
  input  lane_width_e width_i,
  output key_word_t   keys_o
);

  // lfsr state before each lane
  // entry n is the state after n byte times
  logic [15:0] state_chain [`SCR_LANES+1];

  assign state_chain[0] = state_i;

  // one byte step per lane, chained low lane first
  for (genvar i = 0; i < `SCR_LANES; i++) begin : gen_step
    lfsr_byte_step lfsr_byte_step_inst (
      .state_i (state_chain[i]),
      .key_o   (keys_o.key[i]),
      .state_o (state_chain[i+1])
    );
  end

  // pick the advanced state by active lane count
  // every active lane costs one byte time, K or not
  always_comb begin : next_sel
    case (width_i)
      width_8:  keys_o.next_state = state_chain[1];
      width_16: keys_o.next_state = state_chain[2];
      width_32: keys_o.next_state = state_chain[`SCR_LANES];
      // unused encoding treated as full width
      default:  keys_o.next_state = state_chain[`SCR_LANES];
    endcase
  end

endmodule

`default_nettype wire

// ==== source/symbol_classify.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pcie_scramble_config.svh"

module symbol_classify
  import pcie_scramble_pkg::*;
(
  input  pipe_word_t  word_i,
  input  lane_width_e width_i,
  output lane_flags_t flags_o
);

  logic [`SCR_LANES-1:0] active_mask;

  // active lanes grow up from lane 0
  always_comb begin : active_dec
    case (width_i)
      width_8:  active_mask = 4'b0001;
      width_16: active_mask = 4'b0011;
      width_32: active_mask = 4'b1111;
      default:  active_mask = 4'b1111;
    endcase
  end

  // per-lane marking
  // inactive lanes never flag ctrl or com
  always_comb begin : lane_mark
    flags_o.active = active_mask;
    for (int i = 0; i < `SCR_LANES; i++) begin
      // K symbols bypass the xor
      flags_o.ctrl[i] = active_mask[i] & word_i.sym[i].k;
      // COM must be a K code, a data BC is plain data
      flags_o.com[i] = active_mask[i] & word_i.sym[i].k &
                       (word_i.sym[i].data == `SCR_COM);
    end
  end

endmodule

`default_nettype wire

// ==== source/scramble_mix.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pcie_scramble_config.svh"

module scramble_mix
  import pcie_scramble_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_i,
  input  pipe_word_t  word_i,
  input  logic        in_valid_i,
  output logic        in_ready_o,
  input  key_word_t   keys_i,
  input  lane_flags_t flags_i,
  output logic [15:0] state_o,
  output pipe_word_t  word_o,
  output logic        out_valid_o,
  input  logic        out_ready_i
);

  logic [15:0] state_r;
  logic [15:0] state_next;
  logic        out_valid_r;
  pipe_word_t  word_r;
  pipe_word_t  word_mixed;
  logic        accept;

  // room when empty or being drained this cycle
  assign in_ready_o = ~out_valid_r | out_ready_i;
  assign accept     = in_valid_i & in_ready_o;

  // per-lane xor or pass-through
  always_comb begin : lane_mix
    word_mixed = word_i;
    for (int i = 0; i < `SCR_LANES; i++) begin
      if (flags_i.active[i] && !flags_i.ctrl[i]) begin
        // scrambled data, K flag cleared
        word_mixed.sym[i].k    = 1'b0;
        word_mixed.sym[i].data = word_i.sym[i].data ^ keys_i.key[i];
      end
    end
  end

  // COM anywhere in the word restarts the next word
  // keys of this word are unaffected
  assign state_next = (|flags_i.com) ? `SCR_SEED : keys_i.next_state;

  // control state
  always_ff @(posedge clk_i) begin : ctrl_seq
    if (rst_i) begin
      state_r     <= `SCR_SEED;
      out_valid_r <= 1'b0;
    end else begin
      // lfsr moves only on accept, holds under back-pressure
      if (accept) begin
        state_r <= state_next;
      end
      if (accept) begin
        out_valid_r <= 1'b1;
      end else if (out_ready_i) begin
        out_valid_r <= 1'b0;
      end
    end
  end

  // payload register
  always_ff @(posedge clk_i) begin : data_seq
    if (accept) begin
      word_r <= word_mixed;
    end
  end

  assign state_o     = state_r;
  assign word_o      = word_r;
  assign out_valid_o = out_valid_r;

endmodule

`default_nettype wire

// ==== source/gen1_scramble_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module gen1_scramble_top
  import pcie_scramble_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_i,
  // input side
  input  pipe_word_t  word_i,
  input  lane_width_e width_i,
  input  logic        in_valid_i,
  output logic        in_ready_o,
  // output side
  output pipe_word_t  word_o,
  output logic        out_valid_o,
  input  logic        out_ready_i
);

  // current lfsr value from the mixer
  logic [15:0] state;
  // keys and advanced state for this word
  key_word_t   keys;
  // active, K and COM lane masks
  lane_flags_t flags;

  // combinational keystream off the held state
  scramble_keystream scramble_keystream_inst (
    .state_i (state),
    .width_i (width_i),
    .keys_o  (keys)
  );

  // lane classification, same input word
  symbol_classify symbol_classify_inst (
    .word_i  (word_i),
    .width_i (width_i),
    .flags_o (flags)
  );

  // xor, lfsr update and the only register stage
  scramble_mix scramble_mix_inst (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .word_i      (word_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .keys_i      (keys),
    .flags_i     (flags),
    .state_o     (state),
    .word_o      (word_o),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i)
  );

endmodule

`default_nettype wire

// ==== verification/gen1_scramble_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module gen1_scramble_props
  import pcie_scramble_pkg::*;
(
  input logic       clk_i,
  input logic       rst_i,
  input pipe_word_t out_word_i,
  input logic       out_valid_i,
  input logic       out_ready_i,
  input logic       in_ready_i
);

  // failed assertions so far, read by the testbench
  int prop_err_count = 0;

  // output register comes up empty
  reset_clears_valid: assert property (@(posedge clk_i) rst_i |=> !out_valid_i)
    else begin
      $error("out_valid_o high in the cycle after reset");
      prop_err_count++;
    end

  // stalled output holds word and valid
  stall_holds_output: assert property (@(posedge clk_i) disable iff (rst_i)
    (out_valid_i && !out_ready_i) |=> (out_valid_i && $stable(out_word_i)))
    else begin
      $error("output word or valid changed while stalled");
      prop_err_count++;
    end

  // empty register always takes a word
  empty_means_ready: assert property (@(posedge clk_i) disable iff (rst_i)
    !out_valid_i |-> in_ready_i)
    else begin
      $error("in_ready_o low with an empty output register");
      prop_err_count++;
    end

endmodule

bind gen1_scramble_top gen1_scramble_props gen1_scramble_props_inst (
  .clk_i       (clk_i),
  .rst_i       (rst_i),
  .out_word_i  (word_o),
  .out_valid_i (out_valid_o),
  .out_ready_i (out_ready_i),
  .in_ready_i  (in_ready_o)
);

`default_nettype wire

// ==== verification/gen1_scramble_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pcie_scramble_config.svh"

module gen1_scramble_tb
  import pcie_scramble_pkg::*;
();

  // words per test: 8 + 200 + 60 + 60 + 150
  localparam int total_words     = 478;
  localparam int watchdog_cycles = total_words * 20 + 200;
  // cycles allowed for the output to catch up at the end of a test
  localparam int drain_cycles    = 50;

  // known PCIe keystream from seed FFFF, scrambled zero word
  localparam pipe_word_t first_zero_word = {1'b0, 8'h14, 1'b0, 8'hC0,
                                            1'b0, 8'h17, 1'b0, 8'hFF};

  logic        clk_i;
  logic        rst_i;
  pipe_word_t  word_i;
  lane_width_e width_i;
  logic        in_valid_i;
  logic        in_ready_o;
  pipe_word_t  word_o;
  logic        out_valid_o;
  logic        out_ready_i;

  integer      seed = 3460;
  logic        bp_mode = 1'b0;
  logic [15:0] model_state;
  pipe_word_t  exp_q[$];
  int          err_count = 0;
  int          in_count = 0;
  int          out_count = 0;
  int          pass_tests = 0;
  int          fail_tests = 0;

  gen1_scramble_top gen1_scramble_top_inst (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .word_i      (word_i),
    .width_i     (width_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .word_o      (word_o),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i)
  );

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // monitor errors plus bound property failures
  function automatic int total_errors();
    return err_count + gen1_scramble_top_inst.gen1_scramble_props_inst.prop_err_count;
  endfunction

  // reference model, one accepted word
  // serial lfsr, key bit b is the msb before shift b
  task automatic model_accept(input pipe_word_t w, input lane_width_e wd);
    pipe_word_t  exp_word;
    logic [15:0] s;
    logic [7:0]  key;
    logic        fb;
    logic        saw_com;
    int          lanes;
    exp_word = w;
    s        = model_state;
    saw_com  = 1'b0;
    lanes    = (wd == width_8) ? 1 : (wd == width_16) ? 2 : 4;
    for (int lane = 0; lane < lanes; lane++) begin
      for (int b = 0; b < 8; b++) begin
        key[b] = s[15];
        fb     = s[15];
        s      = {s[14:0], 1'b0};
        // taps of x^16+x^5+x^4+x^3+1
        s[0] = s[0] ^ fb;
        s[3] = s[3] ^ fb;
        s[4] = s[4] ^ fb;
        s[5] = s[5] ^ fb;
      end
      if (!w.sym[lane].k) begin
        exp_word.sym[lane] = {1'b0, w.sym[lane].data ^ key};
      end else if (w.sym[lane].data == `SCR_COM) begin
        saw_com = 1'b1;
      end
    end
    exp_q.push_back(exp_word);
    model_state = saw_com ? `SCR_SEED : s;
  endtask

  // pre-edge values only, so no race with the driver
  always @(posedge clk_i) begin : monitor
    pipe_word_t exp_word;
    if (rst_i) begin
      model_state = `SCR_SEED;
    end else begin
      if (out_valid_o && out_ready_i) begin
        assert (exp_q.size() != 0) else begin
          $display("output word at %0t with no input word pending", $time);
          err_count++;
        end
        if (exp_q.size() != 0) begin
          exp_word = exp_q.pop_front();
          assert (word_o === exp_word) else begin
            $display("ERR %0t expected %h got %h", $time, exp_word, word_o);
            err_count++;
          end
        end
        // anchor against the published keystream
        if (out_count == 0) begin
          assert (word_o === first_zero_word) else begin
            $display("ERR %0t first word %h, keystream %h", $time, word_o, first_zero_word);
            err_count++;
          end
        end
        out_count++;
      end
      if (in_valid_i && in_ready_o) begin
        model_accept(word_i, width_i);
        in_count++;
      end
    end
  end

  // sink side, random stalls only in back-pressure mode
  always @(posedge clk_i) begin : ready_drive
    if (bp_mode) begin
      out_ready_i <= ($unsigned($random(seed)) % 3) != 0;
    end else begin
      out_ready_i <= 1'b1;
    end
  end

  // random lanes, k_level out of 16 become K, a quarter of those COM
  function automatic pipe_word_t rand_word(input int k_level);
    pipe_word_t w;
    int         r;
    for (int i = 0; i < `SCR_LANES; i++) begin
      w.sym[i].data = $random(seed);
      r             = $unsigned($random(seed)) % 16;
      w.sym[i].k    = (r < k_level);
      if (r < k_level && (r % 4) == 0) begin
        w.sym[i].data = `SCR_COM;
      end
    end
    return w;
  endfunction

  function automatic lane_width_e rand_width(input int choices);
    int r;
    r = $unsigned($random(seed)) % choices;
    return (r == 0) ? width_8 : (r == 1) ? width_16 : width_32;
  endfunction

  // hold valid until taken, then optional idle gap
  task automatic send_word(input pipe_word_t w, input lane_width_e wd, input int gap);
    word_i     <= w;
    width_i    <= wd;
    in_valid_i <= 1'b1;
    @(posedge clk_i);
    while (!in_ready_o) @(posedge clk_i);
    in_valid_i <= 1'b0;
    repeat (gap) @(posedge clk_i);
  endtask

  // wait for the model queue to empty, bounded
  // a lost word leaves entries behind
  task automatic drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < drain_cycles) begin
      @(posedge clk_i);
      waited++;
    end
    @(posedge clk_i);
  endtask

  task automatic report_test(input string name, input int errs_before);
    int errs;
    errs = total_errors() - errs_before;
    if (errs == 0) begin
      pass_tests++;
      $display("[%0t] %s: ok", $time, name);
    end else begin
      fail_tests++;
      $display("[%0t] %s: FAIL, %0d errors", $time, name, errs);
    end
  endtask

  initial begin : stimulus
    int e0;
    word_i      = '0;
    width_i     = width_32;
    in_valid_i  = 1'b0;
    out_ready_i = 1'b1;
    rst_i       = 1'b1;
    repeat (4) @(posedge clk_i);
    rst_i <= 1'b0;

    // zero word first, keys straight from the seed
    e0 = total_errors();
    send_word('0, width_32, 0);
    for (int n = 1; n < 8; n++) send_word(rand_word(0), width_32, 0);
    drain();
    report_test("seed start", e0);

    e0 = total_errors();
    for (int n = 0; n < 200; n++) send_word(rand_word(0), width_32, 0);
    drain();
    report_test("full rate data", e0);

    // K and COM in random lanes
    e0 = total_errors();
    for (int n = 0; n < 60; n++) send_word(rand_word(4), width_32, 0);
    drain();
    report_test("k and com", e0);

    // narrow words, inactive lanes carry junk K and COM
    e0 = total_errors();
    for (int n = 0; n < 60; n++) send_word(rand_word(4), rand_width(2), 0);
    drain();
    report_test("narrow widths", e0);

    e0 = total_errors();
    bp_mode <= 1'b1;
    for (int n = 0; n < 150; n++) begin
      send_word(rand_word(3), rand_width(3), $unsigned($random(seed)) % 3);
    end
    bp_mode <= 1'b0;
    drain();
    assert (exp_q.size() == 0 && in_count == out_count) else begin
      $display("words lost or duplicated, %0d in and %0d out", in_count, out_count);
      err_count++;
    end
    report_test("back-pressure", e0);

    $display("summary: %0d ok, %0d with errors, %0d words in, %0d out",
             pass_tests, fail_tests, in_count, out_count);
    if (fail_tests == 0 && total_errors() == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

  initial begin : watchdog
    repeat (watchdog_cycles) @(posedge clk_i);
    $display("timeout, run did not finish within %0d cycles", watchdog_cycles);
    $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+source
source/pcie_scramble_pkg.sv
source/lfsr_byte_step.sv
source/scramble_keystream.sv
source/symbol_classify.sv
source/scramble_mix.sv
source/gen1_scramble_top.sv
verification/gen1_scramble_props.sv
verification/gen1_scramble_tb.sv
